/* src/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	// Register and data path width
	localparam int DATA_WIDTH = 32;
	// 32 registers
	localparam int REG_ADDR_WIDTH = 5;
	// Bus word address width
	localparam int BUS_ADDR_WIDTH = 6;

	// Instruction register on the bus, just above the register window
	localparam logic [BUS_ADDR_WIDTH-1:0] INSTR_ADDR = 6'h20;

	// ALU operations
	typedef enum logic [3:0]
	{
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_LUI  = 4'd8
	} aluOp_t;

	////////////////////////////////////////////////////////////////////////////
	// MIPS encodings
	////////////////////////////////////////////////////////////////////////////

	// Opcode field, bits 31..26
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_SLTI  = 6'h0A;
	localparam logic [5:0] OP_ANDI  = 6'h0C;
	localparam logic [5:0] OP_ORI   = 6'h0D;
	localparam logic [5:0] OP_XORI  = 6'h0E;
	localparam logic [5:0] OP_LUI   = 6'h0F;

	// Funct field for R-type, bits 5..0
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_NOR  = 6'h27;
	localparam logic [5:0] FN_SLT  = 6'h2A;
	localparam logic [5:0] FN_SLTU = 6'h2B;

endpackage

`default_nettype wire

/* src/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

module registerFile
#(
	parameter int dataWidth = 32,
	parameter int addrWidth = 5
)
(
	input  wire logic                 clk,
	input  wire logic                 reset,
	input  wire logic [addrWidth-1:0] readAddr1,
	input  wire logic [addrWidth-1:0] readAddr2,
	input  wire logic [addrWidth-1:0] writeAddr,
	input  wire logic [dataWidth-1:0] writeData,
	input  wire logic                 writeEnable,
	output logic      [dataWidth-1:0] readData1,
	output logic      [dataWidth-1:0] readData2
);

	// Number of words
	localparam int depth = 1 << addrWidth;

	// Storage, register 0 is writable like any other
	logic [dataWidth-1:0] regs [0:depth-1];

	////////////////////////////////////////////////////////////////////////////
	// Write port and clear
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// Whole array in one cycle
			for (int i = 0; i < depth; i++)
				regs[i] <= '0;
		end
		else if (writeEnable)
		begin
			regs[writeAddr] <= writeData;
		end
	end

	// Two combinational read ports
	assign readData1 = regs[readAddr1];
	assign readData2 = regs[readAddr2];

	// Bus load or execute must always hand over a clean index
	writeAddrKnown: assert property (
		@(posedge clk) disable iff (reset)
		writeEnable |-> !$isunknown(writeAddr)
	) else $error("registerFile write with unknown address");

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu
(
	input  wire logic [mipsPkg::DATA_WIDTH-1:0] operandA,
	input  wire logic [mipsPkg::DATA_WIDTH-1:0] operandB,
	input  wire mipsPkg::aluOp_t                op,
	output logic      [mipsPkg::DATA_WIDTH-1:0] result
);

	import mipsPkg::*;

	// Compare results, widened to a full word below
	logic signedLess;
	logic unsignedLess;

	assign signedLess   = $signed(operandA) < $signed(operandB);
	assign unsignedLess = operandA < operandB;

	////////////////////////////////////////////////////////////////////////////
	// Operation select
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (op)
			// Wrapping arithmetic, no overflow trap
			ALU_ADD:  result = operandA + operandB;
			ALU_SUB:  result = operandA - operandB;
			ALU_AND:  result = operandA & operandB;
			ALU_OR:   result = operandA | operandB;
			ALU_XOR:  result = operandA ^ operandB;
			ALU_NOR:  result = ~(operandA | operandB);
			// One or zero
			ALU_SLT:  result = {{(DATA_WIDTH-1){1'b0}}, signedLess};
			ALU_SLTU: result = {{(DATA_WIDTH-1){1'b0}}, unsignedLess};
			// Immediate into the upper half, zeros below
			ALU_LUI:  result = {operandB[15:0], 16'h0000};
			default:  result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* src/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder
(
	input  wire logic [mipsPkg::DATA_WIDTH-1:0]     instr,
	output logic      [mipsPkg::REG_ADDR_WIDTH-1:0] rsAddr,
	output logic      [mipsPkg::REG_ADDR_WIDTH-1:0] rtAddr,
	output logic      [mipsPkg::REG_ADDR_WIDTH-1:0] destAddr,
	output logic      [mipsPkg::DATA_WIDTH-1:0]     immOperand,
	output logic                                    useImm,
	output mipsPkg::aluOp_t                         aluOp,
	output logic                                    regWrite
);

	import mipsPkg::*;

	// Instruction fields
	logic [5:0]                opcode;
	logic [5:0]                funct;
	logic [REG_ADDR_WIDTH-1:0] rdAddr;
	logic [15:0]               imm;
	logic [DATA_WIDTH-1:0]     immSigned;
	logic [DATA_WIDTH-1:0]     immZero;

	assign opcode = instr[31:26];
	assign rsAddr = instr[25:21];
	assign rtAddr = instr[20:16];
	assign rdAddr = instr[15:11];
	assign funct  = instr[5:0];
	assign imm    = instr[15:0];

	// Both extensions, picked per opcode
	assign immSigned = {{(DATA_WIDTH-16){imm[15]}}, imm};
	assign immZero   = {{(DATA_WIDTH-16){1'b0}}, imm};

	////////////////////////////////////////////////////////////////////////////
	// Control decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Anything unmatched stays a no-op
		aluOp      = ALU_ADD;
		useImm     = 1'b0;
		regWrite   = 1'b0;
		immOperand = immZero;
		destAddr   = rtAddr;
		case (opcode)
			OP_RTYPE:
			begin
				destAddr = rdAddr;
				regWrite = 1'b1;
				case (funct)
					FN_ADD:  aluOp = ALU_ADD;
					FN_SUB:  aluOp = ALU_SUB;
					FN_AND:  aluOp = ALU_AND;
					FN_OR:   aluOp = ALU_OR;
					FN_XOR:  aluOp = ALU_XOR;
					FN_NOR:  aluOp = ALU_NOR;
					FN_SLT:  aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					// Unknown funct
					default: regWrite = 1'b0;
				endcase
			end
			// Sign extended forms
			OP_ADDI: {aluOp, useImm, regWrite, immOperand} = {ALU_ADD, 2'b11, immSigned};
			OP_SLTI: {aluOp, useImm, regWrite, immOperand} = {ALU_SLT, 2'b11, immSigned};
			// Zero extended forms
			OP_ANDI: {aluOp, useImm, regWrite} = {ALU_AND, 2'b11};
			OP_ORI:  {aluOp, useImm, regWrite} = {ALU_OR, 2'b11};
			OP_XORI: {aluOp, useImm, regWrite} = {ALU_XOR, 2'b11};
			OP_LUI:  {aluOp, useImm, regWrite} = {ALU_LUI, 2'b11};
			default: regWrite = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* src/wbExecPort.sv */
`timescale 1ns/1ps
`default_nettype none

module wbExecPort
(
	input  wire logic                                clk,
	input  wire logic                                reset,
	input  wire logic                                wbCyc,
	input  wire logic                                wbStb,
	input  wire logic                                wbWe,
	input  wire logic [mipsPkg::BUS_ADDR_WIDTH-1:0]  wbAdr,
	input  wire logic [mipsPkg::DATA_WIDTH-1:0]      wbDatW,
	output logic      [mipsPkg::DATA_WIDTH-1:0]      wbDatR,
	output logic                                     wbAck,
	output logic      [mipsPkg::DATA_WIDTH-1:0]      instr,
	input  wire logic [mipsPkg::REG_ADDR_WIDTH-1:0]  rsAddr,
	input  wire logic [mipsPkg::REG_ADDR_WIDTH-1:0]  destAddr,
	input  wire logic                                regWrite,
	input  wire logic [mipsPkg::DATA_WIDTH-1:0]      immOperand,
	input  wire logic                                useImm,
	input  wire logic [mipsPkg::DATA_WIDTH-1:0]      aluResult,
	output logic      [mipsPkg::REG_ADDR_WIDTH-1:0]  readAddr1,
	input  wire logic [mipsPkg::DATA_WIDTH-1:0]      readData1,
	input  wire logic [mipsPkg::DATA_WIDTH-1:0]      readData2,
	output logic      [mipsPkg::DATA_WIDTH-1:0]      operandB,
	output logic      [mipsPkg::REG_ADDR_WIDTH-1:0]  writeAddr,
	output logic      [mipsPkg::DATA_WIDTH-1:0]      writeData,
	output logic                                     writeEnable
);

	import mipsPkg::*;

	logic                  req;
	logic                  isRegAdr;
	logic                  isInstrAdr;
	logic                  ackReg;
	logic                  execPending;
	logic [DATA_WIDTH-1:0] instrReg;
	logic [DATA_WIDTH-1:0] readReg;

	// New request only while ack is low
	assign req        = wbCyc && wbStb && !ackReg;
	assign isRegAdr   = wbAdr[BUS_ADDR_WIDTH-1:REG_ADDR_WIDTH] == '0;
	assign isInstrAdr = wbAdr == INSTR_ADDR;

	////////////////////////////////////////////////////////////////////////////
	// Bus state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ackReg      <= 1'b0;
			execPending <= 1'b0;
			instrReg    <= '0;
		end
		else
		begin
			// Fixed one cycle latency
			ackReg      <= req;
			// Execute runs in the ack cycle
			execPending <= req && wbWe && isInstrAdr;
			if (req && wbWe && isInstrAdr)
				instrReg <= wbDatW;
		end
	end

	// Read data captured at the request edge
	always_ff @(posedge clk)
	begin
		if (req && !wbWe)
			readReg <= isInstrAdr ? instrReg : (isRegAdr ? readData1 : '0);
	end

	assign wbAck  = ackReg;
	assign wbDatR = readReg;
	assign instr  = instrReg;

	// Port 1 belongs to the bus except while executing
	assign readAddr1 = execPending ? rsAddr : wbAdr[REG_ADDR_WIDTH-1:0];
	assign operandB  = useImm ? immOperand : readData2;

	// Write port takes the ALU result in the ack cycle or a direct load
	assign writeEnable = execPending ? regWrite : (req && wbWe && isRegAdr);
	assign writeAddr   = execPending ? destAddr : wbAdr[REG_ADDR_WIDTH-1:0];
	assign writeData   = execPending ? aluResult : wbDatW;

	// Host must hold the request until ack
	ackInCycle: assert property (
		@(posedge clk) disable iff (reset) wbAck |-> (wbCyc && wbStb)
	) else $error("wbAck outside an active bus cycle");

endmodule

`default_nettype wire

/* src/mipsExecUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsExecUnit
(
	input  wire logic                               clk,
	input  wire logic                               reset,
	input  wire logic                               wbCyc,
	input  wire logic                               wbStb,
	input  wire logic                               wbWe,
	input  wire logic [mipsPkg::BUS_ADDR_WIDTH-1:0] wbAdr,
	input  wire logic [mipsPkg::DATA_WIDTH-1:0]     wbDatW,
	output logic      [mipsPkg::DATA_WIDTH-1:0]     wbDatR,
	output logic                                    wbAck
);

	import mipsPkg::*;

	// Decoded instruction
	logic [DATA_WIDTH-1:0]     instr;
	logic [REG_ADDR_WIDTH-1:0] rsAddr;
	logic [REG_ADDR_WIDTH-1:0] rtAddr;
	logic [REG_ADDR_WIDTH-1:0] destAddr;
	logic [DATA_WIDTH-1:0]     immOperand;
	logic                      useImm;
	aluOp_t                    aluOp;
	logic                      regWrite;

	// Register file ports and ALU
	logic [REG_ADDR_WIDTH-1:0] readAddr1;
	logic [DATA_WIDTH-1:0]     readData1;
	logic [DATA_WIDTH-1:0]     readData2;
	logic [DATA_WIDTH-1:0]     operandB;
	logic [DATA_WIDTH-1:0]     aluResult;
	logic [REG_ADDR_WIDTH-1:0] writeAddr;
	logic [DATA_WIDTH-1:0]     writeData;
	logic                      writeEnable;

	registerFile #(.dataWidth(DATA_WIDTH), .addrWidth(REG_ADDR_WIDTH)) regFile0 (
		.clk(clk), .reset(reset),
		.readAddr1(readAddr1), .readAddr2(rtAddr),
		.writeAddr(writeAddr), .writeData(writeData), .writeEnable(writeEnable),
		.readData1(readData1), .readData2(readData2)
	);

	instrDecoder decoder0 (
		.instr(instr), .rsAddr(rsAddr), .rtAddr(rtAddr), .destAddr(destAddr),
		.immOperand(immOperand), .useImm(useImm), .aluOp(aluOp), .regWrite(regWrite)
	);

	// Operand A straight from read port 1
	alu alu0 (.operandA(readData1), .operandB(operandB), .op(aluOp), .result(aluResult));

	wbExecPort port0 (
		.clk(clk), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.instr(instr), .rsAddr(rsAddr), .destAddr(destAddr), .regWrite(regWrite),
		.immOperand(immOperand), .useImm(useImm), .aluResult(aluResult),
		.readAddr1(readAddr1), .readData1(readData1), .readData2(readData2),
		.operandB(operandB),
		.writeAddr(writeAddr), .writeData(writeData), .writeEnable(writeEnable)
	);

endmodule

`default_nettype wire

/* include/execRefModel.svh */
`ifndef EXEC_REF_MODEL_SVH
`define EXEC_REF_MODEL_SVH

// Shadow copy of the register file
logic [31:0] shadowRegs [0:31];

////////////////////////////////////////////////////////////////////////////
// Expected effect of one instruction word
////////////////////////////////////////////////////////////////////////////

// Returns 1 when a register is written
function automatic logic expectedResult(input logic [31:0] instrWord,
	output logic [4:0] dest, output logic [31:0] value);
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic [31:0] immS;
	logic [31:0] immZ;
	rsVal = shadowRegs[instrWord[25:21]];
	rtVal = shadowRegs[instrWord[20:16]];
	immS  = {{16{instrWord[15]}}, instrWord[15:0]};
	immZ  = {16'h0000, instrWord[15:0]};
	// I-type goes to rt
	dest  = instrWord[20:16];
	value = '0;
	expectedResult = 1'b1;
	case (instrWord[31:26])
		OP_RTYPE:
		begin
			dest = instrWord[15:11];
			case (instrWord[5:0])
				FN_ADD:  value = rsVal + rtVal;
				FN_SUB:  value = rsVal - rtVal;
				FN_AND:  value = rsVal & rtVal;
				FN_OR:   value = rsVal | rtVal;
				FN_XOR:  value = rsVal ^ rtVal;
				FN_NOR:  value = ~(rsVal | rtVal);
				FN_SLT:  value = {31'b0, $signed(rsVal) < $signed(rtVal)};
				FN_SLTU: value = {31'b0, rsVal < rtVal};
				default: expectedResult = 1'b0;
			endcase
		end
		OP_ADDI: value = rsVal + immS;
		OP_SLTI: value = {31'b0, $signed(rsVal) < $signed(immS)};
		OP_ANDI: value = rsVal & immZ;
		OP_ORI:  value = rsVal | immZ;
		OP_XORI: value = rsVal ^ immZ;
		OP_LUI:  value = {instrWord[15:0], 16'h0000};
		default: expectedResult = 1'b0;
	endcase
endfunction

`endif

/* bench/mipsExecUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsExecUnitTb;

	import mipsPkg::*;

	// Shadow registers and expectedResult
	`include "execRefModel.svh"

	localparam int NUM_RTYPE = 60;
	localparam int NUM_ITYPE = 60;
	localparam int NUM_BAD   = 16;
	// Give up well after the one cycle ack latency
	localparam int ACK_LIMIT = 8;
	// Bus accesses over the whole run
	localparam int NUM_ACCESSES =
		33 + 64 + 2 * (NUM_RTYPE + NUM_ITYPE + NUM_BAD) + NUM_BAD + 3 * 32;
	// Four clocks allowed per access plus a margin
	localparam int WATCHDOG_CYCLES = NUM_ACCESSES * 4 + 200;

	// Supported encodings
	localparam logic [5:0] R_FUNCTS [0:7] =
		'{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
	localparam logic [5:0] I_OPCODES [0:5] =
		'{OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	// j, beq, addiu, lw, sw and a spare
	localparam logic [5:0] BAD_OPCODES [0:5] =
		'{6'h02, 6'h04, 6'h09, 6'h23, 6'h2B, 6'h3F};
	// sll, jr, mult, addu
	localparam logic [5:0] BAD_FUNCTS [0:3] = '{6'h00, 6'h08, 6'h18, 6'h21};

	logic        clk;
	logic        reset;
	logic        wbCyc;
	logic        wbStb;
	logic        wbWe;
	logic [5:0]  wbAdr;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic        wbAck;

	// Reads waiting for the comparer
	logic [5:0]  readAdrQ [$];
	logic [31:0] readExpQ [$];
	logic [31:0] readActQ [$];

	// Last word written to INSTR_ADDR
	logic [31:0] lastInstr;

	mipsExecUnit dut0 (
		.clk(clk), .reset(reset),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stopWithError(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Wishbone master
	////////////////////////////////////////////////////////////////////////////

	task automatic busCycle(input logic we, input logic [5:0] adr, input logic [31:0] dat,
		output logic [31:0] rdata);
		int cycles;
		@(negedge clk);
		wbCyc  = 1'b1;
		wbStb  = 1'b1;
		wbWe   = we;
		wbAdr  = adr;
		wbDatW = dat;
		cycles = 0;
		do
		begin
			@(negedge clk);
			cycles++;
		end
		while (!wbAck && cycles < ACK_LIMIT);
		if (!wbAck)
			stopWithError($sformatf("no ack from the DUT for address %02h", adr));
		// Exactly one cycle after stb is sampled
		assert (cycles == 1) else
			stopWithError($sformatf("ack came %0d cycles after the request", cycles));
		rdata = wbDatR;
		// Request held over the edge that closes the ack cycle
		@(negedge clk);
		assert (!wbAck) else
			stopWithError("ack stayed high for more than one cycle");
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe  = 1'b0;
	endtask

	task automatic busWrite(input logic [5:0] adr, input logic [31:0] dat);
		logic [31:0] ignored;
		busCycle(1'b1, adr, dat, ignored);
	endtask

	// Result goes to the comparer with its expected value
	task automatic busRead(input logic [5:0] adr, input logic [31:0] expected);
		logic [31:0] actual;
		busCycle(1'b0, adr, 32'h0, actual);
		readAdrQ.push_back(adr);
		readExpQ.push_back(expected);
		readActQ.push_back(actual);
	endtask

	task automatic checkAllRegs();
		for (int i = 0; i < 32; i++)
			busRead(6'(i), shadowRegs[i]);
	endtask

	// Issue one word and read back its destination
	task automatic issueAndCheck(input logic [31:0] word);
		logic        wr;
		logic [4:0]  dest;
		logic [31:0] value;
		wr = expectedResult(word, dest, value);
		busWrite(INSTR_ADDR, word);
		lastInstr = word;
		if (wr)
			shadowRegs[dest] = value;
		busRead({1'b0, dest}, shadowRegs[dest]);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Random instruction words
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] randRType();
		return {OP_RTYPE, 5'($urandom()), 5'($urandom()), 5'($urandom()), 5'b0,
			R_FUNCTS[3'($urandom())]};
	endfunction

	// Immediate fully random so both signs show up
	function automatic logic [31:0] randIType();
		return {I_OPCODES[3'($urandom_range(5))], 5'($urandom()), 5'($urandom()),
			16'($urandom())};
	endfunction

	function automatic logic [31:0] randBadWord();
		if ($urandom_range(1) == 0)
			return {BAD_OPCODES[3'($urandom_range(5))], 26'($urandom())};
		else
			return {OP_RTYPE, 20'($urandom()), BAD_FUNCTS[2'($urandom())]};
	endfunction

	// Comparer drains the read queue every rising edge
	initial
	begin : compareReads
		logic [5:0]  adr;
		logic [31:0] expVal;
		logic [31:0] actVal;
		forever
		begin
			@(posedge clk);
			while (readAdrQ.size() > 0)
			begin
				adr    = readAdrQ.pop_front();
				expVal = readExpQ.pop_front();
				actVal = readActQ.pop_front();
				assert (actVal === expVal) else
					stopWithError($sformatf("MISMATCH wbDatR reg %0d expected %08h actual %08h",
						adr, expVal, actVal));
			end
		end
	end

	initial
	begin
		#(WATCHDOG_CYCLES * 10);
		stopWithError($sformatf("watchdog timeout after %0d cycles", WATCHDOG_CYCLES));
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin : mainSequence
		logic [31:0] value;
		void'($urandom(32'h963cc392));
		reset     = 1'b1;
		wbCyc     = 1'b0;
		wbStb     = 1'b0;
		wbWe      = 1'b0;
		wbAdr     = '0;
		wbDatW    = '0;
		lastInstr = '0;
		for (int i = 0; i < 32; i++)
			shadowRegs[i] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Cleared state and empty instruction register
		checkAllRegs();
		busRead(INSTR_ADDR, 32'h0);

		// Direct loads including register 0
		for (int i = 0; i < 32; i++)
		begin
			value = $urandom();
			busWrite(6'(i), value);
			shadowRegs[i] = value;
		end
		checkAllRegs();

		for (int n = 0; n < NUM_RTYPE; n++)
			issueAndCheck(randRType());
		checkAllRegs();

		for (int n = 0; n < NUM_ITYPE; n++)
			issueAndCheck(randIType());
		checkAllRegs();

		// No-op words and instruction register readback
		for (int n = 0; n < NUM_BAD; n++)
		begin
			issueAndCheck(randBadWord());
			busRead(INSTR_ADDR, lastInstr);
		end
		checkAllRegs();

		// Let the comparer catch up
		@(posedge clk);
		@(negedge clk);
		if (readAdrQ.size() != 0)
			stopWithError("reads left unchecked at the end of the run");
		else
		begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
src/mipsPkg.sv
src/registerFile.sv
src/alu.sv
src/instrDecoder.sv
src/wbExecPort.sv
src/mipsExecUnit.sv
bench/mipsExecUnitTb.sv

/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module mipsExecUnitTb \
		-f files.f --Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
